// File: source/aesPkg.sv
package aesPkg;

  // ----------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------

  // One GF(2^8) element
  typedef logic [7:0]   aesByte;
  // One column, row 0 in the top byte
  typedef logic [31:0]  aesWord;
  // Full state or key, word 0 on top
  typedef logic [127:0] aesBlock;
  // Round index 0 to 10
  typedef logic [3:0]   aesRoundCount;
  // APB data bus
  typedef logic [31:0]  apbData;

  // Final AES-128 round, no MixColumns
  localparam aesRoundCount LastRound = 4'd10;

  // ----------------------------------------------------------
  // Register map, byte offsets
  // ----------------------------------------------------------
  localparam int unsigned CtrlOffset    = 'h00;
  localparam int unsigned StatusOffset  = 'h04;
  // Four words each, word 0 first
  localparam int unsigned KeyOffset     = 'h10;
  localparam int unsigned DataInOffset  = 'h20;
  localparam int unsigned DataOutOffset = 'h30;

  // ----------------------------------------------------------
  // GF(2^8) arithmetic, reduction polynomial 0x11B
  // ----------------------------------------------------------

  // Multiply by x
  function automatic aesByte gfDouble(aesByte a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift and add product
  function automatic aesByte gfMultiply(aesByte a, aesByte b);
    aesByte product;
    aesByte shifted;
    product = '0;
    shifted = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        product = product ^ shifted;
      end
      shifted = gfDouble(shifted);
    end
    return product;
  endfunction

  // a^254 by repeated squaring, zero stays zero
  function automatic aesByte gfInverse(aesByte a);
    aesByte result;
    aesByte power;
    result = 8'h01;
    power  = a;
    for (int i = 1; i < 8; i++)
    begin
      // power holds a^(2^i)
      power  = gfMultiply(power, power);
      result = gfMultiply(result, power);
    end
    return result;
  endfunction

  // Inverse then affine map, constant 0x63
  function automatic aesByte sboxValue(aesByte a);
    aesByte inv;
    inv = gfInverse(a);
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

endpackage

// File: source/aesCoreIf.sv
`timescale 1ns/1ps

interface aesCoreIf;
  import aesPkg::*;

  // Software side inputs to the engine
  aesBlock key;
  aesBlock dataIn;
  // One cycle request
  logic    start;

  // Engine results
  aesBlock dataOut;
  logic    busy;
  // One cycle completion
  logic    done;

  // Register block view
  modport regs (
    output key,
    output dataIn,
    output start,
    input  dataOut,
    input  busy,
    input  done
  );

  // Sequencer view
  modport core (
    input  key,
    input  dataIn,
    input  start,
    output dataOut,
    output busy,
    output done
  );

endinterface

// File: source/aesSubWord.sv
`timescale 1ns/1ps

module aesSubWord (
  input  aesPkg::aesWord wordIn,
  output aesPkg::aesWord wordOut
);
  import aesPkg::*;

  // Byte lanes, row 0 first
  aesByte laneIn  [4];
  aesByte laneOut [4];

  // ----------------------------------------------------------
  // Four independent S-boxes
  // ----------------------------------------------------------
  always_comb
  begin
    for (int b = 0; b < 4; b++)
    begin
      laneIn[b]  = wordIn[31 - 8 * b -: 8];
      // Inverse plus affine, no table
      laneOut[b] = sboxValue(laneIn[b]);
    end
  end

  // Repack lanes into the column
  always_comb
  begin
    wordOut = '0;
    for (int b = 0; b < 4; b++)
    begin
      wordOut[31 - 8 * b -: 8] = laneOut[b];
    end
  end

endmodule

// File: source/aesMixColumn.sv
`timescale 1ns/1ps

module aesMixColumn (
  input  aesPkg::aesWord wordIn,
  output aesPkg::aesWord wordOut
);
  import aesPkg::*;

  // Column bytes, index equals row
  aesByte col [4];
  // Byte times 2
  aesByte dbl [4];
  // Byte times 3
  aesByte tpl [4];

  // Split column and form the multiples
  always_comb
  begin
    for (int r = 0; r < 4; r++)
    begin
      col[r] = wordIn[31 - 8 * r -: 8];
      dbl[r] = gfDouble(col[r]);
      // 3a is 2a plus a
      tpl[r] = dbl[r] ^ col[r];
    end
  end

  // Circulant matrix 02 03 01 01, rotated per row
  always_comb
  begin
    wordOut = '0;
    for (int r = 0; r < 4; r++)
    begin
      wordOut[31 - 8 * r -: 8] = dbl[r] ^ tpl[(r + 1) % 4] ^
                                 col[(r + 2) % 4] ^ col[(r + 3) % 4];
    end
  end

endmodule

// File: source/aesRound.sv
`timescale 1ns/1ps

module aesRound (
  input  aesPkg::aesBlock stateIn,
  input  aesPkg::aesBlock roundKey,
  input  logic            lastRound,
  output aesPkg::aesBlock stateOut
);
  import aesPkg::*;

  // Columns after each step
  aesWord  subCol   [4];
  aesWord  shiftCol [4];
  aesWord  mixCol   [4];
  // Block before AddRoundKey
  aesBlock preKey;

  // ----------------------------------------------------------
  // SubBytes and MixColumns slices
  // ----------------------------------------------------------
  for (genvar c = 0; c < 4; c++)
  begin : columnSlice
    aesSubWord aesSubWord_inst (
      .wordIn  (stateIn[127 - 32 * c -: 32]),
      .wordOut (subCol[c])
    );

    aesMixColumn aesMixColumn_inst (
      .wordIn  (shiftCol[c]),
      .wordOut (mixCol[c])
    );
  end

  // ShiftRows, row r rotated left by r columns
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      shiftCol[c] = '0;
      for (int r = 0; r < 4; r++)
      begin
        shiftCol[c][31 - 8 * r -: 8] = subCol[(c + r) % 4][31 - 8 * r -: 8];
      end
    end
  end

  // Final round skips MixColumns
  always_comb
  begin
    preKey = '0;
    for (int c = 0; c < 4; c++)
    begin
      preKey[127 - 32 * c -: 32] = lastRound ? shiftCol[c] : mixCol[c];
    end
  end

  // AddRoundKey
  assign stateOut = preKey ^ roundKey;

endmodule

// File: source/aesKeyExpand.sv
`timescale 1ns/1ps

module aesKeyExpand (
  input  aesPkg::aesBlock keyIn,
  input  aesPkg::aesByte  rcon,
  output aesPkg::aesBlock keyOut
);
  import aesPkg::*;

  // Current key words, w0 on top
  aesWord w0, w1, w2, w3;
  // RotWord and SubWord results
  aesWord rotWord;
  aesWord subWord;
  // Term fed into the chain
  aesWord temp;

  assign {w0, w1, w2, w3} = keyIn;

  // Rotate last word one byte left
  assign rotWord = {w3[23:0], w3[31:24]};

  aesSubWord aesSubWord_inst (
    .wordIn  (rotWord),
    .wordOut (subWord)
  );

  // Round constant lands in row 0 only
  assign temp = subWord ^ {rcon, 24'h000000};

  // XOR chain through the four words
  assign keyOut[127:96] = w0 ^ temp;
  assign keyOut[95:64]  = w1 ^ keyOut[127:96];
  assign keyOut[63:32]  = w2 ^ keyOut[95:64];
  assign keyOut[31:0]   = w3 ^ keyOut[63:32];

endmodule

// File: source/aesCore.sv
`timescale 1ns/1ps

module aesCore (
  input  logic      clk,
  input  logic      reset,
  aesCoreIf.core    coreBus
);
  import aesPkg::*;

  typedef enum logic {
    Idle,
    Run
  } fsmStateType;

  fsmStateType  fsmState;
  // Round about to be applied
  aesRoundCount round;
  aesByte       rcon;
  // Datapath registers
  aesBlock      cipherState;
  aesBlock      roundKey;
  // Combinational round results
  aesBlock      nextKey;
  aesBlock      roundOut;
  logic         finalRound;
  logic         accept;

  // Start only counts while idle
  assign accept     = (fsmState == Idle) && coreBus.start;
  assign finalRound = (round == LastRound);
  assign coreBus.busy = (fsmState == Run);

  // ----------------------------------------------------------
  // One round per clock
  // ----------------------------------------------------------
  aesKeyExpand aesKeyExpand_inst (
    .keyIn  (roundKey),
    .rcon   (rcon),
    .keyOut (nextKey)
  );

  aesRound aesRound_inst (
    .stateIn   (cipherState),
    .roundKey  (nextKey),
    .lastRound (finalRound),
    .stateOut  (roundOut)
  );

  // Sequencer and result register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fsmState        <= Idle;
      round           <= '0;
      rcon            <= '0;
      coreBus.done    <= 1'b0;
      coreBus.dataOut <= '0;
    end
    else
    begin
      coreBus.done <= 1'b0;
      case (fsmState)
        Idle:
        begin
          if (accept)
          begin
            fsmState <= Run;
            round    <= 4'd1;
            rcon     <= 8'h01;
          end
        end
        Run:
        begin
          round <= round + 4'd1;
          // 01 02 04 ... 80 1b 36
          rcon  <= gfDouble(rcon);
          if (finalRound)
          begin
            fsmState        <= Idle;
            coreBus.done    <= 1'b1;
            coreBus.dataOut <= roundOut;
          end
        end
        default:
        begin
          fsmState <= Idle;
        end
      endcase
    end
  end

  // Initial AddRoundKey on accept, then iterate
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cipherState <= coreBus.dataIn ^ coreBus.key;
      roundKey    <= coreBus.key;
    end
    else if (fsmState == Run)
    begin
      cipherState <= roundOut;
      roundKey    <= nextKey;
    end
  end

endmodule

// File: source/aesApbRegs.sv
`timescale 1ns/1ps

module aesApbRegs #(
  parameter int AddrWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [AddrWidth-1:0] paddr,
  input  aesPkg::apbData       pwdata,
  output aesPkg::apbData       prdata,
  output logic                 pslverr,
  aesCoreIf.regs               coreBus
);
  import aesPkg::*;

  apbData     keyReg  [4];
  apbData     dataReg [4];
  logic       doneSticky;
  // Address decode
  logic       ctrlHit;
  logic [3:0] keyHit;
  logic [3:0] dataHit;
  logic       addrError;
  apbData     readValue;
  // Bus phases
  logic       setupPhase;
  logic       accessWrite;
  // Status bits as software sees them
  logic       busyBit;
  logic       doneBit;

  assign setupPhase  = psel && !penable;
  assign accessWrite = psel && penable && pwrite && !addrError;

  // Pending start already counts as busy and clears done
  assign busyBit = coreBus.busy | coreBus.start;
  assign doneBit = (doneSticky | coreBus.done) & ~coreBus.start;

  assign coreBus.key    = {keyReg[0], keyReg[1], keyReg[2], keyReg[3]};
  assign coreBus.dataIn = {dataReg[0], dataReg[1], dataReg[2], dataReg[3]};

  // ----------------------------------------------------------
  // Decode and read mux
  // ----------------------------------------------------------
  always_comb
  begin
    ctrlHit   = (paddr == AddrWidth'(CtrlOffset));
    keyHit    = '0;
    dataHit   = '0;
    readValue = '0;
    // Unmapped or misaligned unless a match below
    addrError = !ctrlHit;
    if (paddr == AddrWidth'(StatusOffset))
    begin
      readValue = {30'd0, doneBit, busyBit};
      addrError = pwrite;
    end
    for (int i = 0; i < 4; i++)
    begin
      if (paddr == AddrWidth'(KeyOffset + 4 * i))
      begin
        keyHit[i] = 1'b1;
        readValue = keyReg[i];
        addrError = 1'b0;
      end
      if (paddr == AddrWidth'(DataInOffset + 4 * i))
      begin
        dataHit[i] = 1'b1;
        readValue  = dataReg[i];
        addrError  = 1'b0;
      end
      // Result words are read only
      if (paddr == AddrWidth'(DataOutOffset + 4 * i))
      begin
        readValue = coreBus.dataOut[127 - 32 * i -: 32];
        addrError = pwrite;
      end
    end
  end

  // Registers, response and start pulse
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 4; i++)
      begin
        keyReg[i]  <= '0;
        dataReg[i] <= '0;
      end
      coreBus.start <= 1'b0;
      doneSticky    <= 1'b0;
      prdata        <= '0;
      pslverr       <= 1'b0;
    end
    else
    begin
      coreBus.start <= accessWrite && ctrlHit && pwdata[0];
      // Response captured in setup, held through access
      prdata        <= setupPhase ? readValue : '0;
      pslverr       <= setupPhase && addrError;
      if (coreBus.start)
      begin
        doneSticky <= 1'b0;
      end
      else if (coreBus.done)
      begin
        doneSticky <= 1'b1;
      end
      for (int i = 0; i < 4; i++)
      begin
        if (accessWrite && keyHit[i])
        begin
          keyReg[i] <= pwdata;
        end
        if (accessWrite && dataHit[i])
        begin
          dataReg[i] <= pwdata;
        end
      end
    end
  end

endmodule

// File: source/aesTop.sv
`timescale 1ns/1ps

module aesTop #(
  parameter int AddrWidth = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  // APB slave, zero wait
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [AddrWidth-1:0] paddr,
  input  aesPkg::apbData       pwdata,
  output aesPkg::apbData       prdata,
  output logic                 pslverr
);

  // ----------------------------------------------------------
  // Register block to sequencer link
  // ----------------------------------------------------------
  aesCoreIf coreBus ();

  // Software visible registers
  aesApbRegs #(
    .AddrWidth (AddrWidth)
  ) aesApbRegs_inst (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .coreBus (coreBus.regs)
  );

  // Iterative cipher, ten rounds
  aesCore aesCore_inst (
    .clk     (clk),
    .reset   (reset),
    .coreBus (coreBus.core)
  );

endmodule

// File: test/aesTopTb.sv
`timescale 1ns/1ps

module aesTopTb;
  import aesPkg::*;

  localparam int AddrWidth  = 8;
  localparam int DriveDelay = 2;
  // Eleven cycle latency, three clocks per poll
  localparam int PollLimit  = 20;
  // About 100 transfers at three clocks each, wide margin
  localparam int CycleLimit = 2000;

  logic                 clk;
  logic                 reset;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [AddrWidth-1:0] paddr;
  apbData               pwdata;
  apbData               prdata;
  logic                 pslverr;

  int     valueErrors    = 0;
  int     busErrors      = 0;
  int     protocolErrors = 0;
  int     cycleCount     = 0;
  integer seed           = 32'hbcee_4049;
  // Busy tracking for the start monitor
  logic   busyPrev;
  logic   startPending;

  aesTop #(
    .AddrWidth (AddrWidth)
  ) aesTop_inst (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Hard stop on a hung run
  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit)
    begin
      $display("Run stopped after %0d cycles without finishing", cycleCount);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Bus error rules from the register map
  // ----------------------------------------------------------
  function automatic logic accessError(logic [AddrWidth-1:0] addr, logic write);
    logic aligned;
    logic inKey;
    logic inData;
    logic inOut;
    aligned = (addr[1:0] == 2'b00);
    inKey   = aligned && addr >= KeyOffset && addr < KeyOffset + 16;
    inData  = aligned && addr >= DataInOffset && addr < DataInOffset + 16;
    inOut   = aligned && addr >= DataOutOffset && addr < DataOutOffset + 16;
    // Read only registers
    if (write && (addr == StatusOffset || inOut))
    begin
      return 1'b1;
    end
    return !(addr == CtrlOffset || addr == StatusOffset || inKey || inData || inOut);
  endfunction

  // Every access phase, mid cycle
  always @(negedge clk)
  begin
    if (!reset && psel && penable)
    begin
      assert (pslverr === accessError(paddr, pwrite))
      else
      begin
        $display("ERROR pslverr at 0x%02h: got 0x%0h expected 0x%0h",
                 paddr, pslverr, accessError(paddr, pwrite));
        busErrors++;
      end
    end
  end

  // Busy only after a CTRL start write issued while idle
  always @(negedge clk)
  begin
    if (reset)
    begin
      busyPrev     = 1'b0;
      startPending = 1'b0;
    end
    else
    begin
      if (psel && penable && pwrite && paddr == CtrlOffset && pwdata[0] &&
          !aesTop_inst.coreBus.busy)
      begin
        startPending = 1'b1;
      end
      if (aesTop_inst.coreBus.busy && !busyPrev)
      begin
        assert (startPending)
        else
        begin
          $display("Engine went busy without a CTRL start write");
          protocolErrors++;
        end
        startPending = 1'b0;
      end
      busyPrev = aesTop_inst.coreBus.busy;
    end
  end

  // ----------------------------------------------------------
  // APB transfers and checks
  // ----------------------------------------------------------
  task automatic expectEqual(input string name, input apbData got, input apbData exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
      valueErrors++;
    end
  endtask

  task automatic apbWrite(input logic [AddrWidth-1:0] addr, input apbData data,
                          output logic err);
    @(posedge clk);
    #DriveDelay;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #DriveDelay;
    penable = 1'b1;
    // Response stable for the whole access phase
    err     = pslverr;
    @(posedge clk);
    #DriveDelay;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbRead(input logic [AddrWidth-1:0] addr, output apbData data,
                         output logic err);
    @(posedge clk);
    #DriveDelay;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #DriveDelay;
    penable = 1'b1;
    data    = prdata;
    err     = pslverr;
    @(posedge clk);
    #DriveDelay;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic writeBlock(input int unsigned base, input aesBlock block);
    logic err;
    for (int i = 0; i < 4; i++)
    begin
      apbWrite(AddrWidth'(base + 4 * i), block[127 - 32 * i -: 32], err);
    end
  endtask

  task automatic startEngine();
    logic err;
    apbWrite(AddrWidth'(CtrlOffset), 32'h1, err);
  endtask

  task automatic expectStatus(input apbData exp);
    apbData status;
    logic   err;
    apbRead(AddrWidth'(StatusOffset), status, err);
    expectEqual("STATUS", status, exp);
  endtask

  // Poll done, bounded
  task automatic waitDone();
    apbData status;
    logic   err;
    int     polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < PollLimit)
    begin
      apbRead(AddrWidth'(StatusOffset), status, err);
      polls++;
    end
    if (!status[1])
    begin
      $display("Encryption did not finish within %0d STATUS polls", PollLimit);
      protocolErrors++;
    end
  endtask

  task automatic checkResult(input aesBlock exp);
    apbData word;
    logic   err;
    for (int i = 0; i < 4; i++)
    begin
      apbRead(AddrWidth'(DataOutOffset + 4 * i), word, err);
      expectEqual($sformatf("DATAOUT%0d", i), word, exp[127 - 32 * i -: 32]);
    end
  endtask

  task automatic encrypt(input aesBlock key, input aesBlock plain, input aesBlock exp);
    writeBlock(KeyOffset, key);
    writeBlock(DataInOffset, plain);
    startEngine();
    waitDone();
    checkResult(exp);
  endtask

  // ----------------------------------------------------------
  // Test groups
  // ----------------------------------------------------------

  // Busy and done bits, dropped restart, writes while running
  task automatic statusRules();
    logic err;
    writeBlock(KeyOffset, 128'h2b7e151628aed2a6abf7158809cf4f3c);
    writeBlock(DataInOffset, 128'h3243f6a8885a308d313198a2e0370734);
    // Done still set from the last run
    expectStatus(32'h2);
    startEngine();
    expectStatus(32'h1);
    // Key changes before the restart, so a taken restart would alter the result
    apbWrite(AddrWidth'(KeyOffset), 32'hffff_ffff, err);
    apbWrite(AddrWidth'(CtrlOffset), 32'h1, err);
    apbWrite(AddrWidth'(DataInOffset), 32'h0f0f_0f0f, err);
    waitDone();
    checkResult(128'h3925841d02dc09fbdc118597196a0b32);
    expectStatus(32'h2);
  endtask

  task automatic registerReadback();
    apbData keyWords  [4];
    apbData dataWords [4];
    apbData word;
    logic   err;
    for (int i = 0; i < 4; i++)
    begin
      keyWords[i]  = $random(seed);
      dataWords[i] = $random(seed);
      apbWrite(AddrWidth'(KeyOffset + 4 * i), keyWords[i], err);
      apbWrite(AddrWidth'(DataInOffset + 4 * i), dataWords[i], err);
    end
    for (int i = 0; i < 4; i++)
    begin
      apbRead(AddrWidth'(KeyOffset + 4 * i), word, err);
      expectEqual($sformatf("KEY%0d", i), word, keyWords[i]);
      apbRead(AddrWidth'(DataInOffset + 4 * i), word, err);
      expectEqual($sformatf("DATAIN%0d", i), word, dataWords[i]);
    end
  endtask

  task automatic busErrorRules();
    apbData after;
    logic   err;
    apbRead(8'h08, after, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    apbRead(8'h40, after, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    // Misaligned inside the key block
    apbRead(8'h11, after, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    apbWrite(8'h0c, 32'h1234_5678, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    apbWrite(AddrWidth'(StatusOffset), 32'h3, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    // Idle engine, done kept from the last run
    apbRead(AddrWidth'(StatusOffset), after, err);
    expectEqual("STATUS", after, 32'h2);
    apbWrite(AddrWidth'(DataOutOffset + 8), 32'h1234_5678, err);
    expectEqual("pslverr", {31'd0, err}, 32'h1);
    // Third word of the Appendix B ciphertext
    apbRead(AddrWidth'(DataOutOffset + 8), after, err);
    expectEqual("DATAOUT2", after, 32'hdc11_8597);
    // CTRL reads as zero
    apbRead(AddrWidth'(CtrlOffset), after, err);
    expectEqual("CTRL", after, 32'h0);
    expectEqual("pslverr", {31'd0, err}, 32'h0);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge clk);
    #DriveDelay;
    reset = 1'b0;

    // Reset values
    expectEqual("pslverr", {31'd0, pslverr}, 32'h0);
    expectStatus(32'h0);
    checkResult('0);

    // FIPS-197 C.1
    encrypt(128'h000102030405060708090a0b0c0d0e0f,
            128'h00112233445566778899aabbccddeeff,
            128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    // FIPS-197 Appendix B
    encrypt(128'h2b7e151628aed2a6abf7158809cf4f3c,
            128'h3243f6a8885a308d313198a2e0370734,
            128'h3925841d02dc09fbdc118597196a0b32);
    // Same key, new block only
    writeBlock(DataInOffset, 128'h6bc1bee22e409f96e93d7e117393172a);
    startEngine();
    waitDone();
    checkResult(128'h3ad77bb40d7a3660a89ecaf32466ef97);

    statusRules();
    registerReadback();
    busErrorRules();

    repeat (2) @(posedge clk);
    $display("Errors: value %0d, bus %0d, protocol %0d",
             valueErrors, busErrors, protocolErrors);
    if (valueErrors + busErrors + protocolErrors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
source/aesPkg.sv
source/aesCoreIf.sv
source/aesSubWord.sv
source/aesMixColumn.sv
source/aesRound.sv
source/aesKeyExpand.sv
source/aesCore.sv
source/aesApbRegs.sv
source/aesTop.sv
test/aesTopTb.sv

// File: Bender.yml
package:
  name: aes_apb

sources:
  - source/aesPkg.sv
  - source/aesCoreIf.sv
  - source/aesSubWord.sv
  - source/aesMixColumn.sv
  - source/aesRound.sv
  - source/aesKeyExpand.sv
  - source/aesCore.sv
  - source/aesApbRegs.sv
  - source/aesTop.sv
  - target: test
    files:
      - test/aesTopTb.sv
